//--- rtl/board_top.sv
// Board top joining pads, pad control, pin multiplexer, GPIO and registers
`timescale 1ns/1ns

`include "pad_cfg.svh"

module board_top import pad_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cfg_req_i,
  input  cfg_req_t            cfg_i,
  output logic                cfg_ack_o,
  output data_t               cfg_rdata_o,
  input  logic                uart_tx_i,
  output logic                uart_rx_o,
  output logic                intr_o,
  inout  logic [`MIO_NUM-1:0] io_gp,
  input  logic                io_dps0_i,
  input  logic                io_dps1_i,
  output logic                io_dps2_o,
  input  logic                io_dps3_i,
  input  logic                io_dps4_i,
  input  logic                io_dps5_i,
  input  logic                io_dps6_i,
  input  logic                io_dps7_i,
  output logic                jtag_tck_o,
  output logic                jtag_tms_o,
  output logic                jtag_tdi_o,
  output logic                jtag_trst_n_o,
  input  logic                jtag_tdo_i,
  output logic                spi_sck_o,
  output logic                spi_csb_o,
  output logic                spi_mosi_o,
  input  logic                spi_miso_i
);

  pad_drv_t gpio_drv;
  pad_drv_t pad_drv;
  pad_sel_t pad_sel;
  rx_idx_t  rx_sel;
  mio_vec_t intr_en;
  mio_vec_t intr_clr;
  mio_vec_t intr_state;
  mio_vec_t gpio_in;
  mio_vec_t pad_in;

  pinmux_regs i_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_req_i    (cfg_req_i),
    .cfg_i        (cfg_i),
    .cfg_ack_o    (cfg_ack_o),
    .cfg_rdata_o  (cfg_rdata_o),
    .gpio_in_i    (gpio_in),
    .intr_state_i (intr_state),
    .gpio_drv_o   (gpio_drv),
    .pad_sel_o    (pad_sel),
    .rx_sel_o     (rx_sel),
    .intr_en_o    (intr_en),
    .intr_clr_o   (intr_clr)
  );

  pinmux i_pinmux (
    .gpio_drv_i (gpio_drv),
    .pad_sel_i  (pad_sel),
    .rx_sel_i   (rx_sel),
    .uart_tx_i  (uart_tx_i),
    .gpio_in_i  (gpio_in),
    .pad_drv_o  (pad_drv),
    .uart_rx_o  (uart_rx_o)
  );

  gpio i_gpio (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pad_in_i     (pad_in),
    .intr_en_i    (intr_en),
    .intr_clr_i   (intr_clr),
    .gpio_in_o    (gpio_in),
    .intr_state_o (intr_state),
    .intr_o       (intr_o)
  );

  padctl i_padctl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pad_drv_i     (pad_drv),
    .pad_in_o      (pad_in),
    .io_gp         (io_gp),
    .io_dps0_i     (io_dps0_i),
    .io_dps1_i     (io_dps1_i),
    .io_dps2_o     (io_dps2_o),
    .io_dps3_i     (io_dps3_i),
    .io_dps4_i     (io_dps4_i),
    .io_dps5_i     (io_dps5_i),
    .io_dps6_i     (io_dps6_i),
    .io_dps7_i     (io_dps7_i),
    .jtag_tck_o    (jtag_tck_o),
    .jtag_tms_o    (jtag_tms_o),
    .jtag_tdi_o    (jtag_tdi_o),
    .jtag_trst_n_o (jtag_trst_n_o),
    .jtag_tdo_i    (jtag_tdo_i),
    .spi_sck_o     (spi_sck_o),
    .spi_csb_o     (spi_csb_o),
    .spi_mosi_o    (spi_mosi_o),
    .spi_miso_i    (spi_miso_i)
  );

endmodule

//--- rtl/gpio.sv
// Pad input synchroniser with rising-edge interrupt collection
`timescale 1ns/1ns

module gpio import pad_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mio_vec_t pad_in_i,
  input  mio_vec_t intr_en_i,
  input  mio_vec_t intr_clr_i,
  output mio_vec_t gpio_in_o,
  output mio_vec_t intr_state_o,
  output logic     intr_o
);

  mio_vec_t sync1_q;
  mio_vec_t sync2_q;
  mio_vec_t prev_q;
  mio_vec_t rise;
  mio_vec_t state_d;
  mio_vec_t state_q;
  logic     intr_q;

  // Edge seen between the last two synchronised samples
  assign rise = sync2_q & ~prev_q & intr_en_i;

  // Set wins over a clear in the same cycle
  assign state_d = (state_q & ~intr_clr_i) | rise;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      state_q <= '0;
      intr_q  <= 1'b0;
    end else begin
      sync1_q <= pad_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      state_q <= state_d;
      intr_q  <= |state_d; // Tracks the status bits
    end
  end

  assign gpio_in_o    = sync2_q;
  assign intr_state_o = state_q;
  assign intr_o       = intr_q;

endmodule

//--- rtl/pad_cfg.svh
// Pad count, select width, register map and select codes
`ifndef PAD_CFG_SVH
`define PAD_CFG_SVH

`define MIO_NUM 16 // Multiplexed pads, fixed by the register map
`define SEL_W   2  // Select bits per pad
`define RX_W    4  // UART receive pad index
`define ADDR_W  3
`define DATA_W  32

`define REG_GPIO_OUT   3'd0
`define REG_GPIO_OE    3'd1
`define REG_GPIO_IN    3'd2 // Read only
`define REG_SEL_LO     3'd3 // Pads 0 to 7
`define REG_SEL_HI     3'd4 // Pads 8 to 15
`define REG_RX_SEL     3'd5
`define REG_INTR_EN    3'd6
`define REG_INTR_STATE 3'd7 // Write one to clear

`define SEL_GPIO 2'd0
`define SEL_UART 2'd1 // Codes 2 and 3 leave the pad input only

`endif

//--- rtl/pad_pkg.sv
// Vector types and packed structs for the configuration bus and pad drive

`include "pad_cfg.svh"

package pad_pkg;

  // One bit per multiplexed pad
  typedef logic [`MIO_NUM-1:0] mio_vec_t;

  // Two select bits per pad, pad 0 in the low bits
  typedef logic [`MIO_NUM*`SEL_W-1:0] pad_sel_t;

  typedef logic [`RX_W-1:0]   rx_idx_t;
  typedef logic [`ADDR_W-1:0] reg_addr_t;
  typedef logic [`DATA_W-1:0] data_t;

  // Request side of the configuration bus
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    data_t     wdata;
  } cfg_req_t;

  // Output value and enable for every pad
  typedef struct packed {
    mio_vec_t out;
    mio_vec_t oe;
  } pad_drv_t;

endpackage

//--- rtl/padctl.sv
// Tristate GP pad drivers, debug strap latch
// and JTAG or SPI steering of the shared debug pins
`timescale 1ns/1ns

`include "pad_cfg.svh"

module padctl import pad_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  pad_drv_t            pad_drv_i,
  output mio_vec_t            pad_in_o,
  inout  logic [`MIO_NUM-1:0] io_gp,
  input  logic                io_dps0_i, // TCK or SCK
  input  logic                io_dps1_i, // TDI or MOSI
  output logic                io_dps2_o, // TDO or MISO
  input  logic                io_dps3_i, // TMS or CSB
  input  logic                io_dps4_i, // TRST_N
  input  logic                io_dps5_i, // System reset, unused here
  input  logic                io_dps6_i, // Strap, JTAG=0 SPI=1
  input  logic                io_dps7_i, // Bootstrap, unused here
  output logic                jtag_tck_o,
  output logic                jtag_tms_o,
  output logic                jtag_tdi_o,
  output logic                jtag_trst_n_o,
  input  logic                jtag_tdo_i,
  output logic                spi_sck_o,
  output logic                spi_csb_o,
  output logic                spi_mosi_o,
  input  logic                spi_miso_i
);

  logic strap_q;

  for (genvar i = 0; i < `MIO_NUM; i++) begin : g_pad
    assign io_gp[i] = pad_drv_i.oe[i] ? pad_drv_i.out[i] : 1'bz;
  end

  assign pad_in_o = io_gp;

  // Strap follows the pin during reset, then holds
  always_ff @(posedge clk_i) begin
    if (rst_i) strap_q <= io_dps6_i;
  end

  always_comb begin
    if (strap_q) begin
      // SPI device mode, JTAG held in reset
      spi_sck_o     = io_dps0_i;
      spi_csb_o     = io_dps3_i;
      spi_mosi_o    = io_dps1_i;
      io_dps2_o     = spi_miso_i;
      jtag_tck_o    = 1'b0;
      jtag_tms_o    = 1'b1;
      jtag_tdi_o    = 1'b0;
      jtag_trst_n_o = 1'b0;
    end else begin
      jtag_tck_o    = io_dps0_i;
      jtag_tms_o    = io_dps3_i;
      jtag_tdi_o    = io_dps1_i;
      jtag_trst_n_o = io_dps4_i;
      io_dps2_o     = jtag_tdo_i;
      spi_sck_o     = 1'b0;
      spi_csb_o     = 1'b1; // Chip select inactive
      spi_mosi_o    = 1'b0;
    end
  end

endmodule

//--- rtl/pinmux.sv
// Per-pad output source selection and UART receive pad selection
`timescale 1ns/1ns

`include "pad_cfg.svh"

module pinmux import pad_pkg::*; (
  input  pad_drv_t gpio_drv_i,
  input  pad_sel_t pad_sel_i,
  input  rx_idx_t  rx_sel_i,
  input  logic     uart_tx_i,
  input  mio_vec_t gpio_in_i,
  output pad_drv_t pad_drv_o,
  output logic     uart_rx_o
);

  mio_vec_t out_d;
  mio_vec_t oe_d;

  always_comb begin
    logic [`SEL_W-1:0] sel;
    for (int i = 0; i < `MIO_NUM; i++) begin
      sel = pad_sel_i[i*`SEL_W +: `SEL_W];
      case (sel)
        `SEL_GPIO: begin
          out_d[i] = gpio_drv_i.out[i];
          oe_d[i]  = gpio_drv_i.oe[i];
        end
        `SEL_UART: begin
          out_d[i] = uart_tx_i;
          oe_d[i]  = 1'b1; // Transmit always drives
        end
        default: begin
          // Input only
          out_d[i] = 1'b0;
          oe_d[i]  = 1'b0;
        end
      endcase
    end
  end

  assign pad_drv_o.out = out_d;
  assign pad_drv_o.oe  = oe_d;

  // Receive taken from the synchronised inputs
  assign uart_rx_o = gpio_in_i[rx_sel_i];

endmodule

//--- rtl/pinmux_regs.sv
// Configuration registers behind a four-phase req/ack bus
// Holds GPIO drive, pad selects, UART receive select and interrupt enables
`timescale 1ns/1ns

`include "pad_cfg.svh"

module pinmux_regs import pad_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     cfg_req_i,
  input  cfg_req_t cfg_i,
  output logic     cfg_ack_o,
  output data_t    cfg_rdata_o,
  input  mio_vec_t gpio_in_i,
  input  mio_vec_t intr_state_i,
  output pad_drv_t gpio_drv_o,
  output pad_sel_t pad_sel_o,
  output rx_idx_t  rx_sel_o,
  output mio_vec_t intr_en_o,
  output mio_vec_t intr_clr_o
);

  typedef enum logic {IDLE, ACK} hs_state_e;

  hs_state_e state_q;
  logic      start;
  data_t     rdata_d;
  data_t     rdata_q;
  mio_vec_t  gpio_out_q;
  mio_vec_t  gpio_oe_q;
  pad_sel_t  sel_q;
  rx_idx_t   rx_sel_q;
  mio_vec_t  intr_en_q;
  mio_vec_t  intr_clr_q;

  // A request seen in IDLE is accepted on this edge
  assign start = (state_q == IDLE) && cfg_req_i;

  always_comb begin
    case (cfg_i.addr)
      `REG_GPIO_OUT:   rdata_d = data_t'(gpio_out_q);
      `REG_GPIO_OE:    rdata_d = data_t'(gpio_oe_q);
      `REG_GPIO_IN:    rdata_d = data_t'(gpio_in_i);
      `REG_SEL_LO:     rdata_d = data_t'(sel_q[`MIO_NUM-1:0]);
      `REG_SEL_HI:     rdata_d = data_t'(sel_q[2*`MIO_NUM-1:`MIO_NUM]);
      `REG_RX_SEL:     rdata_d = data_t'(rx_sel_q);
      `REG_INTR_EN:    rdata_d = data_t'(intr_en_q);
      default:         rdata_d = data_t'(intr_state_i);
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      sel_q      <= '0; // All pads GPIO
      rx_sel_q   <= '0;
      intr_en_q  <= '0;
      intr_clr_q <= '0;
    end else begin
      intr_clr_q <= '0; // Single-cycle pulse
      case (state_q)
        IDLE: begin
          if (cfg_req_i) begin
            state_q <= ACK;
            if (cfg_i.we) begin
              case (cfg_i.addr)
                `REG_GPIO_OUT:   gpio_out_q <= cfg_i.wdata[`MIO_NUM-1:0];
                `REG_GPIO_OE:    gpio_oe_q  <= cfg_i.wdata[`MIO_NUM-1:0];
                `REG_SEL_LO:     sel_q[`MIO_NUM-1:0] <= cfg_i.wdata[`MIO_NUM-1:0];
                `REG_SEL_HI:     sel_q[2*`MIO_NUM-1:`MIO_NUM] <= cfg_i.wdata[`MIO_NUM-1:0];
                `REG_RX_SEL:     rx_sel_q   <= cfg_i.wdata[`RX_W-1:0];
                `REG_INTR_EN:    intr_en_q  <= cfg_i.wdata[`MIO_NUM-1:0];
                `REG_INTR_STATE: intr_clr_q <= cfg_i.wdata[`MIO_NUM-1:0];
                default: ; // GPIO_IN ignores writes
              endcase
            end
          end
        end
        ACK: begin
          if (!cfg_req_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Read data captured with ack and held until the next request
  always_ff @(posedge clk_i) begin
    if (start) rdata_q <= rdata_d;
  end

  assign cfg_ack_o      = (state_q == ACK);
  assign cfg_rdata_o    = rdata_q;
  assign gpio_drv_o.out = gpio_out_q;
  assign gpio_drv_o.oe  = gpio_oe_q;
  assign pad_sel_o      = sel_q;
  assign rx_sel_o       = rx_sel_q;
  assign intr_en_o      = intr_en_q;
  assign intr_clr_o     = intr_clr_q;

endmodule

//--- tests/board_top_chk.sv
// Concurrent checks on the configuration handshake and the GP pad drive
// Bound into board_top
`timescale 1ns/1ns

`include "pad_cfg.svh"

module board_top_chk import pad_pkg::*; (
  input logic                clk_i,
  input logic                rst_i,
  input logic                req_i,
  input logic                ack_i,
  input logic                uart_tx_i,
  input logic [`MIO_NUM-1:0] pads_i,
  input pad_drv_t            gpio_drv_i,
  input pad_sel_t            pad_sel_i
);

  int unsigned fail_cnt = 0; // Read by the testbench at the end of the run

  a_ack_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i))
    else begin
      $error("ack rose without a pending request");
      fail_cnt++;
    end

  a_ack_fall: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(ack_i) |-> !$past(req_i))
    else begin
      $error("ack fell while the request was still high");
      fail_cnt++;
    end

  a_ack_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> !ack_i)
    else begin
      $error("ack not low after reset");
      fail_cnt++;
    end

  for (genvar i = 0; i < `MIO_NUM; i++) begin : g_pad
    a_gpio_drive: assert property (@(posedge clk_i) disable iff (rst_i)
      (pad_sel_i[i*`SEL_W +: `SEL_W] == `SEL_GPIO && gpio_drv_i.oe[i])
      |-> pads_i[i] === gpio_drv_i.out[i])
      else begin
        $error("pad %0d does not follow its GPIO output bit", i);
        fail_cnt++;
      end

    a_uart_drive: assert property (@(posedge clk_i) disable iff (rst_i)
      (pad_sel_i[i*`SEL_W +: `SEL_W] == `SEL_UART) |-> pads_i[i] === uart_tx_i)
      else begin
        $error("pad %0d does not follow uart_tx_i", i);
        fail_cnt++;
      end
  end

endmodule

bind board_top board_top_chk i_chk (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .req_i      (cfg_req_i),
  .ack_i      (cfg_ack_o),
  .uart_tx_i  (uart_tx_i),
  .pads_i     (io_gp),
  .gpio_drv_i (gpio_drv),
  .pad_sel_i  (pad_sel)
);

//--- tests/tb_board_top.sv
// Bus tasks, pad drivers and a register model driving board_top
// Tests for defaults, GPIO, pin multiplexing, interrupts and the debug strap
`timescale 1ns/1ns

`include "pad_cfg.svh"

module tb_board_top import pad_pkg::*; ();

  localparam time CLK_PERIOD = 20;
  localparam int  N_XACT     = 40;                          // Rough count of bus transactions
  localparam time WATCHDOG   = N_XACT * 250 * CLK_PERIOD;   // 200 us

  logic                clk_i = 1'b0;
  logic                rst_i;
  logic                cfg_req_i;
  cfg_req_t            cfg_i;
  logic                cfg_ack_o;
  data_t               cfg_rdata_o;
  logic                uart_tx_i;
  logic                uart_rx_o;
  logic                intr_o;
  wire [`MIO_NUM-1:0]  io_gp;
  logic                io_dps0_i, io_dps1_i, io_dps3_i, io_dps4_i;
  logic                io_dps5_i, io_dps6_i, io_dps7_i;
  logic                io_dps2_o;
  logic                jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o;
  logic                jtag_tdo_i;
  logic                spi_sck_o, spi_csb_o, spi_mosi_o;
  logic                spi_miso_i;

  mio_vec_t    drv_val;  // Values the testbench puts on released pads
  mio_vec_t    drv_en;
  mio_vec_t    m_out;    // Register model
  mio_vec_t    m_oe;
  pad_sel_t    m_sel;
  logic [31:0] rng;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_err = 0;

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  for (genvar i = 0; i < `MIO_NUM; i++) begin : g_drv
    assign io_gp[i] = drv_en[i] ? drv_val[i] : 1'bz;
  end

  board_top i_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Pads the DUT should drive under the select rules
  function automatic mio_vec_t dut_oe();
    mio_vec_t oe;
    for (int i = 0; i < `MIO_NUM; i++) begin
      case (m_sel[i*`SEL_W +: `SEL_W])
        `SEL_GPIO: oe[i] = m_oe[i];
        `SEL_UART: oe[i] = 1'b1;
        default:   oe[i] = 1'b0;
      endcase
    end
    return oe;
  endfunction

  function automatic mio_vec_t pad_expect();
    mio_vec_t v;
    for (int i = 0; i < `MIO_NUM; i++) begin
      case (m_sel[i*`SEL_W +: `SEL_W])
        `SEL_GPIO: v[i] = m_oe[i] ? m_out[i] : drv_val[i];
        `SEL_UART: v[i] = uart_tx_i;
        default:   v[i] = drv_val[i];
      endcase
    end
    return v;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #2; // Drive point after the edge
  endtask

  task automatic check(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic bus_xfer(input logic we, input reg_addr_t addr, input data_t wdata,
                          output data_t rdata);
    cfg_i.we    = we;
    cfg_i.addr  = addr;
    cfg_i.wdata = wdata;
    cfg_req_i   = 1'b1;
    do tick(); while (!cfg_ack_o);
    rdata     = cfg_rdata_o;
    cfg_req_i = 1'b0;
    do tick(); while (cfg_ack_o);
  endtask

  task automatic reg_write(input reg_addr_t addr, input data_t data);
    data_t    unused;
    mio_vec_t old_oe;
    old_oe = dut_oe();
    case (addr)
      `REG_GPIO_OUT: m_out = data[`MIO_NUM-1:0];
      `REG_GPIO_OE:  m_oe = data[`MIO_NUM-1:0];
      `REG_SEL_LO:   m_sel[`MIO_NUM-1:0] = data[`MIO_NUM-1:0];
      `REG_SEL_HI:   m_sel[2*`MIO_NUM-1:`MIO_NUM] = data[`MIO_NUM-1:0];
      default: ;
    endcase
    drv_en = ~(old_oe | dut_oe()); // Let go early where the DUT takes over
    bus_xfer(1'b1, addr, data, unused);
    drv_en = ~dut_oe();
  endtask

  task automatic reg_check(input reg_addr_t addr, input data_t exp, input string what);
    data_t rd;
    bus_xfer(1'b0, addr, '0, rd);
    check(what, rd, exp);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %s done, %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  task automatic apply_reset(input logic strap);
    io_dps6_i = strap;
    rst_i     = 1'b1;
    tick();
    m_out  = '0; // Registers clear on the first reset edge
    m_oe   = '0;
    m_sel  = '0;
    drv_en = '1;
    repeat (3) tick();
    rst_i = 1'b0;
  endtask

  // Random DPS inputs against the steering of the latched mode
  task automatic debug_check(input logic spi);
    io_dps6_i = ~spi; // Strap pin moves while the latched mode holds
    repeat (4) begin
      rng = xorshift(rng);
      {io_dps0_i, io_dps1_i, io_dps3_i, io_dps4_i, spi_miso_i, jtag_tdo_i} = rng[5:0];
      tick();
      if (spi) begin
        check("spi_sck_o", spi_sck_o, io_dps0_i);
        check("spi_csb_o", spi_csb_o, io_dps3_i);
        check("spi_mosi_o", spi_mosi_o, io_dps1_i);
        check("io_dps2_o", io_dps2_o, spi_miso_i);
        check("jtag idle", {jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o}, 4'b0100);
      end else begin
        check("jtag_tck_o", jtag_tck_o, io_dps0_i);
        check("jtag_tms_o", jtag_tms_o, io_dps3_i);
        check("jtag_tdi_o", jtag_tdi_o, io_dps1_i);
        check("jtag_trst_n_o", jtag_trst_n_o, io_dps4_i);
        check("io_dps2_o", io_dps2_o, jtag_tdo_i);
        check("spi idle", {spi_sck_o, spi_csb_o, spi_mosi_o}, 3'b010);
      end
    end
  endtask

  initial begin
    rst_i      = 1'b1;
    cfg_req_i  = 1'b0;
    cfg_i      = '0;
    uart_tx_i  = 1'b0;
    {io_dps0_i, io_dps1_i, io_dps3_i, io_dps4_i} = '0;
    {io_dps5_i, io_dps6_i, io_dps7_i} = '0;
    jtag_tdo_i = 1'b0;
    spi_miso_i = 1'b0;
    drv_val    = '0;
    drv_en     = '1;
    rng        = 32'd43;

    apply_reset(1'b0);
    check("ack after reset", cfg_ack_o, 1'b0);
    for (int a = 0; a < 8; a++) reg_check(reg_addr_t'(a), '0, $sformatf("reg %0d", a));
    end_test("defaults");

    repeat (4) begin
      rng     = xorshift(rng);
      drv_val = rng[31:16];
      reg_write(`REG_GPIO_OUT, data_t'(rng[15:0]));
      rng = xorshift(rng);
      reg_write(`REG_GPIO_OE, data_t'(rng[15:0]));
      tick();
      check("io_gp", io_gp, pad_expect());
      reg_check(`REG_GPIO_OUT, data_t'(m_out), "GPIO_OUT");
      reg_check(`REG_GPIO_OE, data_t'(m_oe), "GPIO_OE");
    end
    end_test("gpio_out");

    repeat (4) begin
      rng     = xorshift(rng);
      drv_val = rng[15:0];
      repeat (3) tick();
      reg_check(`REG_GPIO_IN, data_t'(pad_expect()), "GPIO_IN");
    end
    end_test("gpio_in");

    // Pad 2 and 9 to UART, pad 5 input only, the rest GPIO inputs
    reg_write(`REG_GPIO_OE, '0);
    reg_write(`REG_SEL_LO, (data_t'(`SEL_UART) << (2*`SEL_W)) | (data_t'(2) << (5*`SEL_W)));
    reg_write(`REG_SEL_HI, data_t'(`SEL_UART) << (1*`SEL_W));
    for (int n = 0; n < 4; n++) begin
      uart_tx_i = n[0];
      rng       = xorshift(rng);
      drv_val   = rng[15:0];
      tick();
      check("uart pad 2", io_gp[2], uart_tx_i);
      check("uart pad 9", io_gp[9], uart_tx_i);
      check("released pad 5", io_gp[5], drv_val[5]);
    end
    reg_write(`REG_RX_SEL, 32'd7);
    for (int n = 0; n < 2; n++) begin
      drv_val[7] = ~n[0];
      repeat (3) tick();
      check("uart_rx_o", uart_rx_o, drv_val[7]);
    end
    end_test("pinmux");

    drv_val[3] = 1'b0;
    drv_val[4] = 1'b0;
    repeat (3) tick();
    reg_write(`REG_INTR_STATE, '1);
    reg_write(`REG_INTR_EN, 32'h8); // Pad 3 only
    drv_val[3] = 1'b1;
    repeat (4) tick();
    reg_check(`REG_INTR_STATE, 32'h8, "INTR_STATE after edge");
    check("intr_o set", intr_o, 1'b1);
    drv_val[4] = 1'b1; // Disabled pad
    repeat (4) tick();
    reg_check(`REG_INTR_STATE, 32'h8, "INTR_STATE disabled edge");
    reg_write(`REG_INTR_STATE, 32'h8);
    tick();
    reg_check(`REG_INTR_STATE, '0, "INTR_STATE after clear");
    check("intr_o cleared", intr_o, 1'b0);
    end_test("interrupt");

    apply_reset(1'b1);
    debug_check(1'b1);
    apply_reset(1'b0);
    debug_check(1'b0);
    reg_check(`REG_SEL_LO, '0, "SEL_LO after reset");
    end_test("strap");

    $display("%0d tests, %0d checks, %0d value errors, %0d assertion failures",
             tests, checks, errors, i_dut.i_chk.fail_cnt);
    if (errors == 0 && i_dut.i_chk.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #WATCHDOG;
    $display("Watchdog expired after %0t ns, the tests did not finish", WATCHDOG);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+rtl
rtl/pad_pkg.sv
rtl/pinmux_regs.sv
rtl/pinmux.sv
rtl/gpio.sv
rtl/padctl.sv
rtl/board_top.sv
tests/board_top_chk.sv
tests/tb_board_top.sv
